// File: design/hazard_pkg.sv
package hazard_pkg;

    // Datapath-independent widths
    localparam int INSTR_W = 32;
    localparam int REG_W   = 5;
    localparam int T_W     = 2;

    typedef logic [T_W-1:0] tnew_t;

    // Tuse of a never-read source exceeds any remaining Tnew
    localparam tnew_t TUSE_INF = tnew_t'(3);

    // Link register written by JAL
    localparam logic [REG_W-1:0] REG_RA = 5'd31;

    typedef enum logic [2:0] {
        CLASS_NOP,
        CLASS_CALC_R,
        CLASS_CALC_I,
        CLASS_MEM_READ,
        CLASS_MEM_WRITE,
        CLASS_BRANCH,
        CLASS_JUMP
    } instr_class_e;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_MEM
    } fwd_src_e;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL  = 6'h00,
        OP_REGIMM   = 6'h01,
        OP_J        = 6'h02,
        OP_JAL      = 6'h03,
        OP_BEQ      = 6'h04,
        OP_BNE      = 6'h05,
        OP_ADDIU    = 6'h09,
        OP_ORI      = 6'h0d,
        OP_LUI      = 6'h0f,
        OP_SPECIAL2 = 6'h1c,
        OP_LW       = 6'h23,
        OP_SW       = 6'h2b
    } opcode_e;

    // Funct field under SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23
    } funct_e;

    // Funct field under SPECIAL2
    typedef enum logic [5:0] {
        FN2_CLZ = 6'h20,
        FN2_CLO = 6'h21
    } funct2_e;

    // REGIMM selects the branch through the rt field
    localparam logic [REG_W-1:0] RT_BGEZ = 5'd1;

endpackage

// File: design/hazard_if.sv
// Register needs and result timing of the instruction in ID
interface id_info_if
    import hazard_pkg::*;
();

    logic [REG_W-1:0] rs;
    logic [REG_W-1:0] rt;
    logic [REG_W-1:0] dest;
    tnew_t            tuse_rs;
    tnew_t            tuse_rt;
    tnew_t            tnew_id;

    modport src (output rs, output rt, output dest,
                 output tuse_rs, output tuse_rt, output tnew_id);
    modport dst (input rs, input rt, input dest,
                 input tuse_rs, input tuse_rt, input tnew_id);

endinterface

// Pending results held in EX and MEM
interface stage_if
    import hazard_pkg::*;
();

    logic [REG_W-1:0] ex_dest;
    tnew_t            ex_tnew;
    logic [REG_W-1:0] mem_dest;
    tnew_t            mem_tnew;

    modport src (output ex_dest, output ex_tnew, output mem_dest, output mem_tnew);
    modport dst (input ex_dest, input ex_tnew, input mem_dest, input mem_tnew);

endinterface

// File: design/instr_classifier.sv
module instr_classifier
    import hazard_pkg::*;
(
    input  logic [INSTR_W-1:0] instr,
    id_info_if.src             info
);

    logic [5:0]       opcode;
    logic [5:0]       funct;
    logic [REG_W-1:0] rs_f;
    logic [REG_W-1:0] rt_f;
    logic [REG_W-1:0] rd_f;

    instr_class_e iclass;

    logic is_shift;
    logic is_lui;
    logic is_clx;
    logic is_beq_bne;
    logic is_jal;
    logic is_jalr;

    assign opcode = instr[31:26];
    assign rs_f   = instr[25:21];
    assign rt_f   = instr[20:16];
    assign rd_f   = instr[15:11];
    assign funct  = instr[5:0];

    // Class decode where anything unlisted falls to NOP
    always_comb begin
        iclass = CLASS_NOP;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_ADDU, FN_SUBU, FN_SLL, FN_SRL, FN_SRA: iclass = CLASS_CALC_R;
                    FN_JR, FN_JALR:                           iclass = CLASS_JUMP;
                    default:                                  iclass = CLASS_NOP;
                endcase
            end
            OP_SPECIAL2: begin
                if (funct == FN2_CLZ || funct == FN2_CLO) begin
                    iclass = CLASS_CALC_R;
                end
            end
            OP_ORI, OP_ADDIU, OP_LUI: iclass = CLASS_CALC_I;
            OP_LW:                    iclass = CLASS_MEM_READ;
            OP_SW:                    iclass = CLASS_MEM_WRITE;
            OP_BEQ, OP_BNE:           iclass = CLASS_BRANCH;
            OP_REGIMM: begin
                if (rt_f == RT_BGEZ) begin
                    iclass = CLASS_BRANCH;
                end
            end
            OP_J, OP_JAL:             iclass = CLASS_JUMP;
            default:                  iclass = CLASS_NOP;
        endcase
    end

    // Per-instruction exceptions inside a class
    assign is_shift   = (opcode == OP_SPECIAL) &&
                        (funct == FN_SLL || funct == FN_SRL || funct == FN_SRA);
    assign is_lui     = (opcode == OP_LUI);
    assign is_clx     = (opcode == OP_SPECIAL2);
    assign is_beq_bne = (opcode == OP_BEQ) || (opcode == OP_BNE);
    assign is_jal     = (opcode == OP_JAL);
    assign is_jalr    = (opcode == OP_SPECIAL) && (funct == FN_JALR);

    always_comb begin
        info.rs      = rs_f;
        info.rt      = rt_f;
        info.dest    = '0;
        info.tuse_rs = TUSE_INF;
        info.tuse_rt = TUSE_INF;
        info.tnew_id = '0;
        case (iclass)
            CLASS_CALC_R: begin
                info.dest    = rd_f;
                info.tuse_rs = is_shift ? TUSE_INF : tnew_t'(1);
                info.tuse_rt = is_clx ? TUSE_INF : tnew_t'(1);
                info.tnew_id = tnew_t'(2);
            end
            CLASS_CALC_I: begin
                info.dest    = rt_f;
                info.tuse_rs = is_lui ? TUSE_INF : tnew_t'(1);
                info.tnew_id = is_lui ? tnew_t'(1) : tnew_t'(2);
            end
            CLASS_MEM_READ: begin
                info.dest    = rt_f;
                info.tuse_rs = tnew_t'(1);
                info.tnew_id = tnew_t'(3);
            end
            CLASS_MEM_WRITE: begin
                info.tuse_rs = tnew_t'(1);
                // Store data is needed only in MEM
                info.tuse_rt = tnew_t'(2);
            end
            CLASS_BRANCH: begin
                info.tuse_rs = '0;
                info.tuse_rt = is_beq_bne ? tnew_t'(0) : TUSE_INF;
            end
            CLASS_JUMP: begin
                if (is_jal) begin
                    info.dest = REG_RA;
                end else if (is_jalr) begin
                    info.dest = rd_f;
                end
                info.tnew_id = (is_jal || is_jalr) ? tnew_t'(1) : tnew_t'(0);
            end
            default: begin
                // NOP reads and writes nothing
                info.rs = '0;
                info.rt = '0;
            end
        endcase
    end

endmodule

// File: design/stall_control.sv
module stall_control
    import hazard_pkg::*;
(
    id_info_if.dst info,
    stage_if.dst   stages,
    output logic   stall
);

    logic stall_rs_ex;
    logic stall_rs_mem;
    logic stall_rt_ex;
    logic stall_rt_mem;

    // One source against one pending result
    function automatic logic conflict(
        input logic [REG_W-1:0] src,
        input tnew_t            tuse,
        input logic [REG_W-1:0] dest,
        input tnew_t            tnew
    );
        return (src != '0) && (src == dest) && (tnew > tuse);
    endfunction

    assign stall_rs_ex  = conflict(info.rs, info.tuse_rs, stages.ex_dest, stages.ex_tnew);
    assign stall_rs_mem = conflict(info.rs, info.tuse_rs, stages.mem_dest, stages.mem_tnew);
    assign stall_rt_ex  = conflict(info.rt, info.tuse_rt, stages.ex_dest, stages.ex_tnew);
    assign stall_rt_mem = conflict(info.rt, info.tuse_rt, stages.mem_dest, stages.mem_tnew);

    // Freezes PC and ID, bubbles EX
    assign stall = stall_rs_ex | stall_rs_mem | stall_rt_ex | stall_rt_mem;

endmodule

// File: design/stage_tracker.sv
module stage_tracker
    import hazard_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall,
    id_info_if.dst info,
    stage_if.src   stages
);

    logic [REG_W-1:0] ex_dest_q;
    tnew_t            ex_tnew_q;
    logic [REG_W-1:0] mem_dest_q;
    tnew_t            mem_tnew_q;

    tnew_t ex_tnew_next;
    tnew_t mem_tnew_next;

    // One cycle closer to the result and never below zero
    function automatic tnew_t dec_sat(input tnew_t t);
        tnew_t r;
        r = (t == '0) ? '0 : t - tnew_t'(1);
        return r;
    endfunction

    assign ex_tnew_next  = dec_sat(info.tnew_id);
    assign mem_tnew_next = dec_sat(ex_tnew_q);

    // EX entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_dest_q <= '0;
            ex_tnew_q <= '0;
        end else if (stall) begin
            // Bubble while ID is held
            ex_dest_q <= '0;
            ex_tnew_q <= '0;
        end else begin
            ex_dest_q <= info.dest;
            ex_tnew_q <= ex_tnew_next;
        end
    end

    // MEM entry follows EX every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_dest_q <= '0;
            mem_tnew_q <= '0;
        end else begin
            mem_dest_q <= ex_dest_q;
            mem_tnew_q <= mem_tnew_next;
        end
    end

    assign stages.ex_dest  = ex_dest_q;
    assign stages.ex_tnew  = ex_tnew_q;
    assign stages.mem_dest = mem_dest_q;
    assign stages.mem_tnew = mem_tnew_q;

endmodule

// File: design/forward_select.sv
module forward_select
    import hazard_pkg::*;
(
    id_info_if.dst   info,
    stage_if.dst     stages,
    output fwd_src_e fwd_rs,
    output fwd_src_e fwd_rt
);

    // Youngest ready result wins, so EX is checked before MEM
    function automatic fwd_src_e pick(
        input logic [REG_W-1:0] src,
        input logic [REG_W-1:0] ex_dest,
        input tnew_t            ex_tnew,
        input logic [REG_W-1:0] mem_dest,
        input tnew_t            mem_tnew
    );
        fwd_src_e sel;
        sel = FWD_RF;
        if (src != '0) begin
            if (ex_dest == src && ex_tnew == '0) begin
                sel = FWD_EX;
            end else if (mem_dest == src && mem_tnew == '0) begin
                sel = FWD_MEM;
            end
        end
        return sel;
    endfunction

    assign fwd_rs = pick(info.rs, stages.ex_dest, stages.ex_tnew,
                         stages.mem_dest, stages.mem_tnew);
    assign fwd_rt = pick(info.rt, stages.ex_dest, stages.ex_tnew,
                         stages.mem_dest, stages.mem_tnew);

endmodule

// File: design/hazard_top.sv
module hazard_top
    import hazard_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [INSTR_W-1:0] instr,
    output logic               stall,
    output fwd_src_e           fwd_rs,
    output fwd_src_e           fwd_rt
);

    id_info_if id_info ();
    stage_if   stages ();

    // Decode of the word sitting in ID
    instr_classifier u_instr_classifier (
        .instr (instr),
        .info  (id_info.src)
    );

    stall_control u_stall_control (
        .info   (id_info.dst),
        .stages (stages.dst),
        .stall  (stall)
    );

    // EX and MEM destination and Tnew registers
    stage_tracker u_stage_tracker (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .info   (id_info.dst),
        .stages (stages.src)
    );

    forward_select u_forward_select (
        .info   (id_info.dst),
        .stages (stages.dst),
        .fwd_rs (fwd_rs),
        .fwd_rt (fwd_rt)
    );

endmodule

// File: test/hazard_checker.sv
module hazard_checker
    import hazard_pkg::*;
(
    input logic               clk,
    input logic               rst_n,
    input logic [INSTR_W-1:0] instr,
    input logic               stall,
    input fwd_src_e           fwd_rs,
    input fwd_src_e           fwd_rt,
    input logic [REG_W-1:0]   rs,
    input logic [REG_W-1:0]   rt,
    input logic [REG_W-1:0]   ex_dest,
    input tnew_t              ex_tnew
);

    // Count of failed assertions
    int fail_count = 0;

    // Both stages hold bubbles when reset ends
    assert property (@(posedge clk) $rose(rst_n) |-> !stall)
        else begin
            $error("stall high in the first cycle after reset");
            fail_count++;
        end

    // Longest wait is a remaining Tnew of 2
    assert property (@(posedge clk) disable iff (!rst_n)
        (stall && $past(stall) && $stable(instr)) |=> !stall)
        else begin
            $error("stall held longer than two cycles on one instruction");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) (rs == '0) |-> (fwd_rs == FWD_RF))
        else begin
            $error("forward reported for rs equal to register 0");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) (rt == '0) |-> (fwd_rt == FWD_RF))
        else begin
            $error("forward reported for rt equal to register 0");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> (ex_dest == '0 && ex_tnew == '0))
        else begin
            $error("EX entry is not a bubble after a stall");
            fail_count++;
        end

endmodule

bind hazard_top hazard_checker u_hazard_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .instr   (instr),
    .stall   (stall),
    .fwd_rs  (fwd_rs),
    .fwd_rt  (fwd_rt),
    .rs      (id_info.rs),
    .rt      (id_info.rt),
    .ex_dest (stages.ex_dest),
    .ex_tnew (stages.ex_tnew)
);

// File: test/tb_hazard_top.sv
module tb_hazard_top
    import hazard_pkg::*;
();

    localparam tnew_t T0 = tnew_t'(0);
    localparam tnew_t T1 = tnew_t'(1);
    localparam tnew_t T2 = tnew_t'(2);
    localparam tnew_t T3 = tnew_t'(3);

    logic               clk;
    logic               rst_n;
    logic [INSTR_W-1:0] instr;
    logic               stall;
    fwd_src_e           fwd_rs;
    fwd_src_e           fwd_rt;

    // Expected decode of the word in ID
    logic [REG_W-1:0] cur_rs;
    logic [REG_W-1:0] cur_rt;
    logic [REG_W-1:0] cur_dest;
    tnew_t            cur_tuse_rs;
    tnew_t            cur_tuse_rt;
    tnew_t            cur_tnew;

    // Reference copy of the EX and MEM pending results
    logic [REG_W-1:0] m_ex_dest;
    tnew_t            m_ex_tnew;
    logic [REG_W-1:0] m_mem_dest;
    tnew_t            m_mem_tnew;

    int errors;
    int test_errors;
    int tests_passed;
    int tests_failed;

    hazard_top DUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .instr  (instr),
        .stall  (stall),
        .fwd_rs (fwd_rs),
        .fwd_rt (fwd_rt)
    );

    always #20 clk = ~clk;

    function automatic tnew_t count_down(input tnew_t t);
        return (t == '0) ? T0 : t - T1;
    endfunction

    function automatic logic model_stall();
        logic s;
        s = 1'b0;
        if (cur_rs != '0) begin
            s = s | (cur_rs == m_ex_dest && m_ex_tnew > cur_tuse_rs);
            s = s | (cur_rs == m_mem_dest && m_mem_tnew > cur_tuse_rs);
        end
        if (cur_rt != '0) begin
            s = s | (cur_rt == m_ex_dest && m_ex_tnew > cur_tuse_rt);
            s = s | (cur_rt == m_mem_dest && m_mem_tnew > cur_tuse_rt);
        end
        return s;
    endfunction

    function automatic fwd_src_e model_fwd(input logic [REG_W-1:0] src);
        if (src == '0) return FWD_RF;
        if (src == m_ex_dest && m_ex_tnew == '0) return FWD_EX;
        if (src == m_mem_dest && m_mem_tnew == '0) return FWD_MEM;
        return FWD_RF;
    endfunction

    // A stalled instruction leaves a bubble behind in EX
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_ex_dest  <= '0;
            m_ex_tnew  <= '0;
            m_mem_dest <= '0;
            m_mem_tnew <= '0;
        end else begin
            m_ex_dest  <= model_stall() ? '0 : cur_dest;
            m_ex_tnew  <= model_stall() ? T0 : count_down(cur_tnew);
            m_mem_dest <= m_ex_dest;
            m_mem_tnew <= count_down(m_ex_tnew);
        end
    end

    function automatic logic [INSTR_W-1:0] enc_r(input logic [5:0] funct,
            input logic [REG_W-1:0] rs, input logic [REG_W-1:0] rt, input logic [REG_W-1:0] rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [INSTR_W-1:0] enc_i(input logic [5:0] op,
            input logic [REG_W-1:0] rs, input logic [REG_W-1:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic issue(input logic [INSTR_W-1:0] word, input logic [REG_W-1:0] rs,
            input tnew_t tuse_rs, input logic [REG_W-1:0] rt, input tnew_t tuse_rt,
            input logic [REG_W-1:0] dest, input tnew_t tnew);
        @(posedge clk);
        instr       <= word;
        cur_rs      <= rs;
        cur_tuse_rs <= tuse_rs;
        cur_rt      <= rt;
        cur_tuse_rt <= tuse_rt;
        cur_dest    <= dest;
        cur_tnew    <= tnew;
    endtask

    task automatic put_addu(input logic [REG_W-1:0] rd, rs, rt);
        issue(enc_r(FN_ADDU, rs, rt, rd), rs, T1, rt, T1, rd, T2);
    endtask

    task automatic put_ori(input logic [REG_W-1:0] rt, rs);
        issue(enc_i(OP_ORI, rs, rt, 16'h00ff), rs, T1, rt, TUSE_INF, rt, T2);
    endtask

    task automatic put_lw(input logic [REG_W-1:0] rt, rs);
        issue(enc_i(OP_LW, rs, rt, 16'h0010), rs, T1, rt, TUSE_INF, rt, T3);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("[FAIL] %s: stall expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_fwd(input string name, input fwd_src_e exp, input fwd_src_e act);
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("[FAIL] %s: forward expected %s, actual %s (%0d)",
                     name, exp.name(), act.name(), act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            test_errors++;
            $display("[FAIL] %s: stall cycles expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_model(input string name);
        check_bit(name, model_stall(), stall);
        check_fwd(name, model_fwd(cur_rs), fwd_rs);
        check_fwd(name, model_fwd(cur_rt), fwd_rt);
    endtask

    // Instruction stays in ID until stall drops
    task automatic settle(input string name, output int stalls);
        stalls = 0;
        @(negedge clk);
        compare_model(name);
        while (stall === 1'b1 && stalls < 10) begin
            stalls++;
            @(negedge clk);
            compare_model(name);
        end
        if (stall !== 1'b0) begin
            $display("Timeout in %s: stall did not drop within 10 cycles", name);
            $display(">>> FAIL");
            $finish;
        end
    endtask

    // Empty EX and MEM before each test
    task automatic start_test(input string name);
        int n;
        test_errors = 0;
        repeat (2) begin
            issue('0, '0, TUSE_INF, '0, TUSE_INF, '0, T0);
            settle(name, n);
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) tests_passed++;
        else tests_failed++;
        $display("Test %s finished with %0d errors", name, test_errors);
    endtask

    task automatic test_independent();
        string            name;
        int               base;
        int               i;
        int               n;
        logic [REG_W-1:0] dest;
        name = "independent_stream";
        start_test(name);
        base = int'($urandom % 16);
        for (i = 0; i < 8; i++) begin
            // Sources in 1..15 and distinct destinations in 16..31
            dest = 5'(16 + (base + i) % 16);
            if (i % 2 == 0) put_addu(dest, 5'(1 + $urandom % 15), 5'(1 + $urandom % 15));
            else put_ori(dest, 5'(1 + $urandom % 15));
            settle(name, n);
            check_count(name, 0, n);
            check_fwd(name, FWD_RF, fwd_rs);
            check_fwd(name, FWD_RF, fwd_rt);
        end
        end_test(name);
    endtask

    task automatic test_load_use();
        int n;
        start_test("load_use");
        put_lw(5'd9, 5'd2);
        settle("load_use", n);
        put_addu(5'd10, 5'd9, 5'd3);
        settle("load_use", n);
        check_count("load_use", 1, n);
        // Load result is still one cycle away in MEM so rs comes from the register file
        check_fwd("load_use", FWD_RF, fwd_rs);
        end_test("load_use");
    endtask

    task automatic test_alu_branch();
        int n;
        start_test("alu_to_branch");
        put_addu(5'd12, 5'd4, 5'd5);
        settle("alu_to_branch", n);
        issue(enc_i(OP_BEQ, 5'd12, 5'd6, 16'h0004), 5'd12, T0, 5'd6, T0, '0, T0);
        settle("alu_to_branch", n);
        check_count("alu_to_branch", 1, n);
        check_fwd("alu_to_branch", FWD_MEM, fwd_rs);
        put_addu(5'd13, 5'd4, 5'd5);
        settle("alu_to_branch", n);
        put_ori(5'd20, 5'd7);
        settle("alu_to_branch", n);
        issue(enc_i(OP_BEQ, 5'd13, 5'd6, 16'h0004), 5'd13, T0, 5'd6, T0, '0, T0);
        settle("alu_to_branch", n);
        check_count("alu_to_branch", 0, n);
        check_fwd("alu_to_branch", FWD_MEM, fwd_rs);
        end_test("alu_to_branch");
    endtask

    task automatic test_store_after_load();
        int n;
        start_test("store_after_load");
        put_lw(5'd14, 5'd2);
        settle("store_after_load", n);
        issue(enc_i(OP_SW, 5'd3, 5'd14, 16'h0020), 5'd3, T1, 5'd14, T2, '0, T0);
        settle("store_after_load", n);
        check_count("store_after_load", 0, n);
        check_fwd("store_after_load", FWD_RF, fwd_rt);
        issue(enc_i(OP_LUI, 5'd0, 5'd15, 16'h1234), '0, TUSE_INF, 5'd15, TUSE_INF, 5'd15, T1);
        settle("store_after_load", n);
        put_addu(5'd16, 5'd15, 5'd4);
        settle("store_after_load", n);
        check_count("store_after_load", 0, n);
        check_fwd("store_after_load", FWD_EX, fwd_rs);
        end_test("store_after_load");
    endtask

    task automatic test_zero_and_inf();
        int n;
        start_test("zero_and_inf_tuse");
        put_lw(5'd0, 5'd2);
        settle("zero_and_inf_tuse", n);
        put_addu(5'd17, 5'd0, 5'd0);
        settle("zero_and_inf_tuse", n);
        check_count("zero_and_inf_tuse", 0, n);
        check_fwd("zero_and_inf_tuse", FWD_RF, fwd_rs);
        check_fwd("zero_and_inf_tuse", FWD_RF, fwd_rt);
        put_lw(5'd18, 5'd2);
        settle("zero_and_inf_tuse", n);
        // Shift with rs naming the pending load target
        issue(enc_r(FN_SLL, 5'd18, 5'd4, 5'd19), 5'd18, TUSE_INF, 5'd4, T1, 5'd19, T2);
        settle("zero_and_inf_tuse", n);
        check_count("zero_and_inf_tuse", 0, n);
        end_test("zero_and_inf_tuse");
    endtask

    initial begin
        void'($urandom(31));
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr        = '0;
        cur_rs       = '0;
        cur_rt       = '0;
        cur_dest     = '0;
        cur_tuse_rs  = TUSE_INF;
        cur_tuse_rt  = TUSE_INF;
        cur_tnew     = T0;
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        test_independent();
        test_load_use();
        test_alu_branch();
        test_store_after_load();
        test_zero_and_inf();
        $display("Tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, errors, DUT.u_hazard_checker.fail_count);
        if (errors == 0 && DUT.u_hazard_checker.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
design/hazard_pkg.sv
design/hazard_if.sv
design/instr_classifier.sv
design/stall_control.sv
design/stage_tracker.sv
design/forward_select.sv
design/hazard_top.sv
test/hazard_checker.sv
test/tb_hazard_top.sv

// File: Makefile
TOOL       = verilator
TOP        = tb_hazard_top
FILELIST   = all.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx '$(PASS_TEXT)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
